//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= noc_bridge_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/$(TOP): $(shell cat $(FLIST) | grep -v '^+')
	$(VERILATOR) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)

sim: $(OBJ_DIR)/$(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+hw
hw/noc_bridge_pkg.sv
hw/credit_to_valrdy.sv
hw/link_tx_arbiter.sv
hw/link_rx_demux.sv
hw/valrdy_to_credit.sv
hw/noc_bridge_top.sv
test/noc_bridge_props.sv
test/noc_bridge_tb.sv

//--- hw/credit_to_valrdy.sv
// outbound channel queue: processor valid/yummy in, valid/ready out
`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module credit_to_valrdy
(
   input  logic                  core_ref_clk,
   input  logic                  rst_n,

   // processor side, credit flow control
   input  logic                  noc_in_valid,
   input  noc_bridge_pkg::flit_t noc_in_data,
   output logic                  noc_in_yummy,

   // link side, valid/ready
   output logic                  tx_valid,
   output noc_bridge_pkg::flit_t tx_data,
   input  logic                  tx_ready
);

   localparam int PTR_W = $clog2(`NOC_QUEUE_DEPTH);

   noc_bridge_pkg::flit_t          mem [`NOC_QUEUE_DEPTH];
   logic [PTR_W-1:0]               wr_ptr;
   logic [PTR_W-1:0]               rd_ptr;
   logic [`NOC_CREDIT_WIDTH-1:0]   count;
   logic                           push;
   logic                           pop;

   // processor only sends with a credit in hand, so a push always fits
   assign push = noc_in_valid;
   assign pop  = tx_valid && tx_ready;

   // offered from the cycle after the write
   assign tx_valid = (count != '0);
   assign tx_data  = mem[rd_ptr];

   ////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge core_ref_clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= noc_in_data;
      end
   end

   ////////////////////////////////////////////////////////////
   // pointers, count and yummy
   ////////////////////////////////////////////////////////////

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge core_ref_clk)
   begin
      if (!rst_n)
      begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         noc_in_yummy <= 1'b0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + PTR_W'(1);
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + PTR_W'(1);
         end
         count <= count + `NOC_CREDIT_WIDTH'(push) - `NOC_CREDIT_WIDTH'(pop);
         // one credit back to the processor per entry freed
         noc_in_yummy <= pop;
      end
   end

endmodule

//--- hw/link_rx_demux.sv
// link receive input register and channel tag decode into per-channel writes
`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module link_rx_demux
(
   input  logic                          core_ref_clk,
   input  logic                          rst_n,

   // off-chip link, no back-pressure
   input  noc_bridge_pkg::flit_t         link_in_data,
   input  noc_bridge_pkg::link_channel_e link_in_channel,

   // to the inbound channel queues
   output logic [`NOC_NUM_CHANNELS-1:0]  rx_write,
   output noc_bridge_pkg::flit_t         rx_data
);

   noc_bridge_pkg::flit_t          data_q;
   noc_bridge_pkg::link_channel_e  chan_q;

   // input buffer flops, tag resets to idle
   always_ff @(posedge core_ref_clk)
   begin
      if (!rst_n)
      begin
         data_q <= '0;
         chan_q <= noc_bridge_pkg::LINK_IDLE;
      end
      else
      begin
         data_q <= link_in_data;
         chan_q <= link_in_channel;
      end
   end

   // one strobe per tagged flit, none for idle
   always_comb
   begin
      for (int i = 0; i < `NOC_NUM_CHANNELS; i++)
      begin
         rx_write[i] = (chan_q == noc_bridge_pkg::link_channel_e'(i + 1));
      end
   end

   assign rx_data = data_q;

endmodule

//--- hw/link_tx_arbiter.sv
// round-robin link transmit arbiter with per-channel remote credit counters
`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module link_tx_arbiter
(
   input  logic                          core_ref_clk,
   input  logic                          rst_n,

   // from the outbound channel queues
   input  logic [`NOC_NUM_CHANNELS-1:0]  tx_valid,
   input  noc_bridge_pkg::flit_t         tx_data [`NOC_NUM_CHANNELS],
   output logic [`NOC_NUM_CHANNELS-1:0]  tx_ready,

   // off-chip link
   input  logic [`NOC_NUM_CHANNELS-1:0]  link_credit_back_in,
   output noc_bridge_pkg::flit_t         link_out_data,
   output noc_bridge_pkg::link_channel_e link_out_channel
);

   localparam int IDX_W = $clog2(`NOC_NUM_CHANNELS);

   logic [`NOC_CREDIT_WIDTH-1:0]   remote_credit [`NOC_NUM_CHANNELS];
   logic [`NOC_NUM_CHANNELS-1:0]   eligible;
   logic [`NOC_NUM_CHANNELS-1:0]   grant;
   logic [IDX_W-1:0]               grant_idx;
   logic                           grant_any;
   logic [IDX_W-1:0]               last_idx;
   noc_bridge_pkg::link_channel_e  rr_ptr;
   noc_bridge_pkg::link_channel_e  grant_tag;

   ////////////////////////////////////////////////////////////
   // grant selection
   ////////////////////////////////////////////////////////////

   // a channel competes only with a flit and a remote credit
   always_comb
   begin
      for (int i = 0; i < `NOC_NUM_CHANNELS; i++)
      begin
         eligible[i] = tx_valid[i] && (remote_credit[i] != '0);
      end
   end

   // tag to index, noc1 is channel 0
   assign last_idx = IDX_W'(rr_ptr) - IDX_W'(1);

   // search starts at the channel after the last grant
   always_comb
   begin
      int cand;
      grant     = '0;
      grant_idx = '0;
      grant_any = 1'b0;
      for (int k = 1; k <= `NOC_NUM_CHANNELS; k++)
      begin
         cand = (int'(last_idx) + k) % `NOC_NUM_CHANNELS;
         if (!grant_any && eligible[cand])
         begin
            grant[cand] = 1'b1;
            grant_idx   = IDX_W'(cand);
            grant_any   = 1'b1;
         end
      end
   end

   assign grant_tag = noc_bridge_pkg::link_channel_e'(grant_idx + IDX_W'(1));
   assign tx_ready  = grant;

   ////////////////////////////////////////////////////////////
   // link output and pointer
   ////////////////////////////////////////////////////////////

   // pointer starts on noc3 so noc1 wins first
   always_ff @(posedge core_ref_clk)
   begin
      if (!rst_n)
      begin
         rr_ptr           <= noc_bridge_pkg::LINK_NOC3;
         link_out_channel <= noc_bridge_pkg::LINK_IDLE;
      end
      else
      begin
         link_out_channel <= grant_any ? grant_tag : noc_bridge_pkg::LINK_IDLE;
         if (grant_any)
         begin
            rr_ptr <= grant_tag;
         end
      end
   end

   // data only means something with a non-idle tag
   always_ff @(posedge core_ref_clk)
   begin
      if (grant_any)
      begin
         link_out_data <= tx_data[grant_idx];
      end
   end

   ////////////////////////////////////////////////////////////
   // remote credits
   ////////////////////////////////////////////////////////////

   // send and credit-back in the same cycle cancel out
   always_ff @(posedge core_ref_clk)
   begin
      for (int i = 0; i < `NOC_NUM_CHANNELS; i++)
      begin
         if (!rst_n)
         begin
            remote_credit[i] <= `NOC_CREDIT_WIDTH'(`NOC_QUEUE_DEPTH);
         end
         else
         begin
            remote_credit[i] <= remote_credit[i]
                              - `NOC_CREDIT_WIDTH'(grant[i])
                              + `NOC_CREDIT_WIDTH'(link_credit_back_in[i]);
         end
      end
   end

endmodule

//--- hw/noc_bridge_cfg.svh
// flit width, channel count, queue depth and credit counter width for the noc bridge
`ifndef NOC_BRIDGE_CFG_SVH
`define NOC_BRIDGE_CFG_SVH

////////////////////////////////////////////////////////////
// link and flit
////////////////////////////////////////////////////////////

// flit and off-chip link data width
`define NOC_FLIT_WIDTH 32

// noc1, noc2, noc3
`define NOC_NUM_CHANNELS 3

////////////////////////////////////////////////////////////
// queues and credits
////////////////////////////////////////////////////////////

// entries per channel queue, also the initial credit count
`define NOC_QUEUE_DEPTH 4

// wide enough to hold NOC_QUEUE_DEPTH
`define NOC_CREDIT_WIDTH 3

`endif

//--- hw/noc_bridge_pkg.sv
// flit type and off-chip link channel tag enum
`include "noc_bridge_cfg.svh"

package noc_bridge_pkg;

   ////////////////////////////////////////////////////////////
   // payload
   ////////////////////////////////////////////////////////////

   // one network flit, same width as the link data
   typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;

   ////////////////////////////////////////////////////////////
   // link channel tag
   ////////////////////////////////////////////////////////////

   // 2-bit tag carried with every link flit
   // idle marks an empty link cycle
   typedef enum logic [1:0]
   {
      LINK_IDLE = 2'd0,
      LINK_NOC1 = 2'd1,
      LINK_NOC2 = 2'd2,
      LINK_NOC3 = 2'd3
   } link_channel_e;

endpackage

//--- hw/noc_bridge_top.sv
// off-chip bridge top: outbound queues, link arbiter, link demux, inbound queues
`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module noc_bridge_top
(
   input  logic                          core_ref_clk,
   input  logic                          rst_n,

   // processor to bridge, per channel
   input  logic [`NOC_NUM_CHANNELS-1:0]  noc_in_valid,
   input  noc_bridge_pkg::flit_t         noc_in_data [`NOC_NUM_CHANNELS],
   output logic [`NOC_NUM_CHANNELS-1:0]  noc_in_yummy,

   // bridge to processor, per channel
   output logic [`NOC_NUM_CHANNELS-1:0]  noc_out_valid,
   output noc_bridge_pkg::flit_t         noc_out_data [`NOC_NUM_CHANNELS],
   input  logic [`NOC_NUM_CHANNELS-1:0]  noc_out_yummy,

   // outgoing link
   output noc_bridge_pkg::flit_t         link_out_data,
   output noc_bridge_pkg::link_channel_e link_out_channel,
   input  logic [`NOC_NUM_CHANNELS-1:0]  link_credit_back_in,

   // incoming link
   input  noc_bridge_pkg::flit_t         link_in_data,
   input  noc_bridge_pkg::link_channel_e link_in_channel,
   output logic [`NOC_NUM_CHANNELS-1:0]  link_credit_back_out
);

   logic [`NOC_NUM_CHANNELS-1:0]   tx_valid;
   logic [`NOC_NUM_CHANNELS-1:0]   tx_ready;
   noc_bridge_pkg::flit_t          tx_data [`NOC_NUM_CHANNELS];
   logic [`NOC_NUM_CHANNELS-1:0]   rx_write;
   noc_bridge_pkg::flit_t          rx_data;

   ////////////////////////////////////////////////////////////
   // outbound, processor to link
   ////////////////////////////////////////////////////////////

   // index 0 is noc1
   for (genvar i = 0; i < `NOC_NUM_CHANNELS; i++)
   begin : g_tx
      credit_to_valrdy u_c2v
      (
         .core_ref_clk (core_ref_clk),
         .rst_n        (rst_n),
         .noc_in_valid (noc_in_valid[i]),
         .noc_in_data  (noc_in_data[i]),
         .noc_in_yummy (noc_in_yummy[i]),
         .tx_valid     (tx_valid[i]),
         .tx_data      (tx_data[i]),
         .tx_ready     (tx_ready[i])
      );
   end

   link_tx_arbiter u_arb
   (
      .core_ref_clk        (core_ref_clk),
      .rst_n               (rst_n),
      .tx_valid            (tx_valid),
      .tx_data             (tx_data),
      .tx_ready            (tx_ready),
      .link_credit_back_in (link_credit_back_in),
      .link_out_data       (link_out_data),
      .link_out_channel    (link_out_channel)
   );

   ////////////////////////////////////////////////////////////
   // inbound, link to processor
   ////////////////////////////////////////////////////////////

   link_rx_demux u_demux
   (
      .core_ref_clk    (core_ref_clk),
      .rst_n           (rst_n),
      .link_in_data    (link_in_data),
      .link_in_channel (link_in_channel),
      .rx_write        (rx_write),
      .rx_data         (rx_data)
   );

   // write data is shared, the strobe picks the queue
   for (genvar i = 0; i < `NOC_NUM_CHANNELS; i++)
   begin : g_rx
      valrdy_to_credit u_v2c
      (
         .core_ref_clk         (core_ref_clk),
         .rst_n                (rst_n),
         .rx_write             (rx_write[i]),
         .rx_data              (rx_data),
         .noc_out_valid        (noc_out_valid[i]),
         .noc_out_data         (noc_out_data[i]),
         .noc_out_yummy        (noc_out_yummy[i]),
         .link_credit_back_out (link_credit_back_out[i])
      );
   end

endmodule

//--- hw/valrdy_to_credit.sv
// inbound channel queue: link writes in, processor valid/yummy out, link credit-back
`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module valrdy_to_credit
(
   input  logic                  core_ref_clk,
   input  logic                  rst_n,

   // from the link demux
   input  logic                  rx_write,
   input  noc_bridge_pkg::flit_t rx_data,

   // processor side, credit flow control
   output logic                  noc_out_valid,
   output noc_bridge_pkg::flit_t noc_out_data,
   input  logic                  noc_out_yummy,

   // one pulse per freed entry
   output logic                  link_credit_back_out
);

   localparam int PTR_W = $clog2(`NOC_QUEUE_DEPTH);

   noc_bridge_pkg::flit_t          mem [`NOC_QUEUE_DEPTH];
   logic [PTR_W-1:0]               wr_ptr;
   logic [PTR_W-1:0]               rd_ptr;
   logic [`NOC_CREDIT_WIDTH-1:0]   count;
   logic [`NOC_CREDIT_WIDTH-1:0]   proc_credit;
   logic                           pop;

   // leaves whenever there is a flit and the processor has room
   assign pop           = (count != '0) && (proc_credit != '0);
   assign noc_out_valid = pop;
   assign noc_out_data  = mem[rd_ptr];

   ////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////

   // the remote side holds link credits, so a write always fits
   always_ff @(posedge core_ref_clk)
   begin
      if (rx_write)
      begin
         mem[wr_ptr] <= rx_data;
      end
   end

   ////////////////////////////////////////////////////////////
   // pointers, count and credits
   ////////////////////////////////////////////////////////////

   always_ff @(posedge core_ref_clk)
   begin
      if (!rst_n)
      begin
         wr_ptr               <= '0;
         rd_ptr               <= '0;
         count                <= '0;
         proc_credit          <= `NOC_CREDIT_WIDTH'(`NOC_QUEUE_DEPTH);
         link_credit_back_out <= 1'b0;
      end
      else
      begin
         if (rx_write)
         begin
            wr_ptr <= wr_ptr + PTR_W'(1);
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + PTR_W'(1);
         end
         count <= count + `NOC_CREDIT_WIDTH'(rx_write) - `NOC_CREDIT_WIDTH'(pop);
         // yummy from the processor returns what a pop spent
         proc_credit <= proc_credit - `NOC_CREDIT_WIDTH'(pop)
                      + `NOC_CREDIT_WIDTH'(noc_out_yummy);
         link_credit_back_out <= pop;
      end
   end

endmodule

//--- test/noc_bridge_props.sv
// concurrent assertions on link credits, inbound queue space and credit-back pulses
`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module noc_bridge_props
(
   input logic                          core_ref_clk,
   input logic                          rst_n,
   input noc_bridge_pkg::link_channel_e link_out_channel,
   input logic [`NOC_NUM_CHANNELS-1:0]  link_credit_back_in,
   input logic [`NOC_NUM_CHANNELS-1:0]  rx_write,
   input logic [`NOC_NUM_CHANNELS-1:0]  noc_out_valid,
   input logic [`NOC_NUM_CHANNELS-1:0]  link_credit_back_out
);

   logic [`NOC_NUM_CHANNELS-1:0] link_hit;
   logic [`NOC_NUM_CHANNELS-1:0] credit_back_q;
   logic [`NOC_CREDIT_WIDTH-1:0] in_flight [`NOC_NUM_CHANNELS];
   logic [`NOC_CREDIT_WIDTH-1:0] occupancy [`NOC_NUM_CHANNELS];
   logic [`NOC_CREDIT_WIDTH-1:0] unreturned [`NOC_NUM_CHANNELS];

   // channel of the flit now on the link
   always_comb
   begin
      for (int i = 0; i < `NOC_NUM_CHANNELS; i++)
      begin
         link_hit[i] = (link_out_channel == noc_bridge_pkg::link_channel_e'(i + 1));
      end
   end

   // counts seen from the link and queue ports
   // credit-back delayed one cycle to line up with the registered link output
   always_ff @(posedge core_ref_clk)
   begin
      if (!rst_n)
      begin
         credit_back_q <= '0;
      end
      else
      begin
         credit_back_q <= link_credit_back_in;
      end
      for (int i = 0; i < `NOC_NUM_CHANNELS; i++)
      begin
         if (!rst_n)
         begin
            in_flight[i]  <= '0;
            occupancy[i]  <= '0;
            unreturned[i] <= '0;
         end
         else
         begin
            in_flight[i]  <= in_flight[i] + `NOC_CREDIT_WIDTH'(link_hit[i])
                           - `NOC_CREDIT_WIDTH'(credit_back_q[i]);
            occupancy[i]  <= occupancy[i] + `NOC_CREDIT_WIDTH'(rx_write[i])
                           - `NOC_CREDIT_WIDTH'(noc_out_valid[i]);
            unreturned[i] <= unreturned[i] + `NOC_CREDIT_WIDTH'(rx_write[i])
                           - `NOC_CREDIT_WIDTH'(link_credit_back_out[i]);
         end
      end
   end

   for (genvar i = 0; i < `NOC_NUM_CHANNELS; i++)
   begin : g_chk
      a_no_send_without_credit : assert property (@(posedge core_ref_clk) disable iff (!rst_n)
         link_hit[i] |-> (in_flight[i] < `NOC_CREDIT_WIDTH'(`NOC_QUEUE_DEPTH)))
         else $error("channel %0d sent with no remote credit", i);

      a_no_write_when_full : assert property (@(posedge core_ref_clk) disable iff (!rst_n)
         rx_write[i] |-> (occupancy[i] != `NOC_CREDIT_WIDTH'(`NOC_QUEUE_DEPTH)))
         else $error("inbound write on channel %0d hit a full queue", i);

      a_credit_back_per_flit : assert property (@(posedge core_ref_clk) disable iff (!rst_n)
         link_credit_back_out[i] |-> (unreturned[i] != '0))
         else $error("channel %0d returned a link credit with no flit owed", i);
   end

endmodule

bind noc_bridge_top noc_bridge_props u_props
(
   .core_ref_clk         (core_ref_clk),
   .rst_n                (rst_n),
   .link_out_channel     (link_out_channel),
   .link_credit_back_in  (link_credit_back_in),
   .rx_write             (rx_write),
   .noc_out_valid        (noc_out_valid),
   .link_credit_back_out (link_credit_back_out)
);

//--- test/noc_bridge_tb.sv
// directed testbench for the noc bridge with processor and link side models
`timescale 1ns/1ps
`include "noc_bridge_cfg.svh"

module noc_bridge_tb;

   localparam int NCH     = `NOC_NUM_CHANNELS;
   localparam int DEPTH   = `NOC_QUEUE_DEPTH;
   localparam int TIMEOUT = 400;

   logic                          core_ref_clk;
   logic                          rst_n;
   logic [NCH-1:0]                noc_in_valid;
   noc_bridge_pkg::flit_t         noc_in_data [NCH];
   logic [NCH-1:0]                noc_in_yummy;
   logic [NCH-1:0]                noc_out_valid;
   noc_bridge_pkg::flit_t         noc_out_data [NCH];
   logic [NCH-1:0]                noc_out_yummy;
   noc_bridge_pkg::flit_t         link_out_data;
   noc_bridge_pkg::link_channel_e link_out_channel;
   logic [NCH-1:0]                link_credit_back_in;
   noc_bridge_pkg::flit_t         link_in_data;
   noc_bridge_pkg::link_channel_e link_in_channel;
   logic [NCH-1:0]                link_credit_back_out;

   // scoreboards
   noc_bridge_pkg::flit_t exp_out [NCH][$];
   noc_bridge_pkg::flit_t exp_in [NCH][$];
   int                    link_seq [$];

   // processor and link side models
   int proc_tx_credit [NCH];
   int yummy_cnt [NCH];
   int link_sent [NCH];
   int cb_pending [NCH];
   int manual_cb [NCH];
   int link_credit [NCH];
   int delivered [NCH];
   int yummy_owed [NCH];
   int cb_out_cnt [NCH];
   bit auto_cb;
   bit auto_yummy;

   noc_bridge_top UUT
   (
      .core_ref_clk         (core_ref_clk),
      .rst_n                (rst_n),
      .noc_in_valid         (noc_in_valid),
      .noc_in_data          (noc_in_data),
      .noc_in_yummy         (noc_in_yummy),
      .noc_out_valid        (noc_out_valid),
      .noc_out_data         (noc_out_data),
      .noc_out_yummy        (noc_out_yummy),
      .link_out_data        (link_out_data),
      .link_out_channel     (link_out_channel),
      .link_credit_back_in  (link_credit_back_in),
      .link_in_data         (link_in_data),
      .link_in_channel      (link_in_channel),
      .link_credit_back_out (link_credit_back_out)
   );

   initial
   begin
      core_ref_clk = 1'b0;
      forever
      begin
         #2 core_ref_clk = ~core_ref_clk;
      end
   end

   ////////////////////////////////////////////////////////////
   // error reporting
   ////////////////////////////////////////////////////////////

   task automatic stop_on_error(input string what);
      $display("error at %0t: %s", $time, what);
      $display("RESULT: FAIL");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (expected === actual)
      else
      begin
         $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
         stop_on_error("value mismatch");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // monitors, sampled at the falling edge
   ////////////////////////////////////////////////////////////

   always @(negedge core_ref_clk)
   begin
      int ch;
      if (rst_n)
      begin
         for (int c = 0; c < NCH; c++)
         begin
            if (noc_in_yummy[c])
            begin
               yummy_cnt[c]++;
               proc_tx_credit[c]++;
            end
            if (link_credit_back_out[c])
            begin
               cb_out_cnt[c]++;
               link_credit[c]++;
            end
            if (noc_out_valid[c])
            begin
               assert (exp_in[c].size() > 0)
               else stop_on_error($sformatf("unexpected flit on noc_out channel %0d", c));
               check_value($sformatf("noc_out_data[%0d]", c), exp_in[c].pop_front(),
                           noc_out_data[c]);
               delivered[c]++;
               yummy_owed[c]++;
            end
         end
         if (link_out_channel != noc_bridge_pkg::LINK_IDLE)
         begin
            ch = int'(link_out_channel) - 1;
            assert (exp_out[ch].size() > 0)
            else stop_on_error($sformatf("unexpected flit on link for channel %0d", ch));
            check_value("link_out_data", exp_out[ch].pop_front(), link_out_data);
            link_sent[ch]++;
            cb_pending[ch]++;
            link_seq.push_back(ch);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // credit return drivers
   ////////////////////////////////////////////////////////////

   // remote side frees one link credit per received flit
   always @(posedge core_ref_clk)
   begin
      for (int c = 0; c < NCH; c++)
      begin
         if (rst_n && cb_pending[c] > 0 && (auto_cb || manual_cb[c] > 0))
         begin
            link_credit_back_in[c] <= 1'b1;
            cb_pending[c]--;
            if (!auto_cb)
            begin
               manual_cb[c]--;
            end
         end
         else
         begin
            link_credit_back_in[c] <= 1'b0;
         end
      end
   end

   // processor consumes each delivered flit and returns a yummy
   always @(posedge core_ref_clk)
   begin
      for (int c = 0; c < NCH; c++)
      begin
         if (rst_n && auto_yummy && yummy_owed[c] > 0)
         begin
            noc_out_yummy[c] <= 1'b1;
            yummy_owed[c]--;
         end
         else
         begin
            noc_out_yummy[c] <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus and wait helpers
   ////////////////////////////////////////////////////////////

   task automatic send_outbound(input int n0, input int n1, input int n2);
      int remaining [NCH];
      int t;
      noc_bridge_pkg::flit_t d;
      remaining = '{n0, n1, n2};
      t = 0;
      while (remaining[0] + remaining[1] + remaining[2] > 0)
      begin
         @(posedge core_ref_clk);
         for (int c = 0; c < NCH; c++)
         begin
            if (remaining[c] > 0 && proc_tx_credit[c] > 0)
            begin
               d = $urandom;
               noc_in_valid[c] <= 1'b1;
               noc_in_data[c]  <= d;
               exp_out[c].push_back(d);
               proc_tx_credit[c]--;
               remaining[c]--;
            end
            else
            begin
               noc_in_valid[c] <= 1'b0;
            end
         end
         t++;
         if (t > TIMEOUT)
         begin
            stop_on_error("timeout waiting for processor credits on outbound send");
         end
      end
      @(posedge core_ref_clk);
      noc_in_valid <= '0;
   endtask

   task automatic send_inbound(input int n0, input int n1, input int n2);
      int remaining [NCH];
      int t;
      int rr;
      bit sent;
      noc_bridge_pkg::flit_t d;
      remaining = '{n0, n1, n2};
      t  = 0;
      rr = 0;
      while (remaining[0] + remaining[1] + remaining[2] > 0)
      begin
         @(posedge core_ref_clk);
         sent = 1'b0;
         for (int k = 0; k < NCH; k++)
         begin
            if (!sent && remaining[(rr + k) % NCH] > 0 && link_credit[(rr + k) % NCH] > 0)
            begin
               d = $urandom;
               link_in_channel <= noc_bridge_pkg::link_channel_e'(2'((rr + k) % NCH + 1));
               link_in_data    <= d;
               exp_in[(rr + k) % NCH].push_back(d);
               link_credit[(rr + k) % NCH]--;
               remaining[(rr + k) % NCH]--;
               rr   = (rr + k + 1) % NCH;
               sent = 1'b1;
            end
         end
         if (!sent)
         begin
            link_in_channel <= noc_bridge_pkg::LINK_IDLE;
         end
         t++;
         if (t > TIMEOUT)
         begin
            stop_on_error("timeout waiting for link credits on inbound send");
         end
      end
      @(posedge core_ref_clk);
      link_in_channel <= noc_bridge_pkg::LINK_IDLE;
   endtask

   task automatic wait_link_sent(input int ch, input int n);
      int t;
      t = 0;
      while (link_sent[ch] < n)
      begin
         @(negedge core_ref_clk);
         t++;
         if (t > TIMEOUT)
         begin
            stop_on_error($sformatf("timeout waiting for link flits on channel %0d", ch));
         end
      end
   endtask

   task automatic wait_delivered(input int ch, input int n);
      int t;
      t = 0;
      while (delivered[ch] < n)
      begin
         @(negedge core_ref_clk);
         t++;
         if (t > TIMEOUT)
         begin
            stop_on_error($sformatf("timeout waiting for noc_out flits on channel %0d", ch));
         end
      end
   endtask

   // all flits on the link and all credits home
   task automatic wait_outbound_idle();
      int t;
      t = 0;
      while (exp_out[0].size() + exp_out[1].size() + exp_out[2].size() > 0
             || cb_pending[0] + cb_pending[1] + cb_pending[2] > 0
             || proc_tx_credit[0] + proc_tx_credit[1] + proc_tx_credit[2] != NCH * DEPTH)
      begin
         @(negedge core_ref_clk);
         t++;
         if (t > TIMEOUT)
         begin
            stop_on_error("timeout waiting for the outbound path to drain");
         end
      end
      repeat (2) @(negedge core_ref_clk);
   endtask

   task automatic wait_inbound_idle();
      int t;
      t = 0;
      while (exp_in[0].size() + exp_in[1].size() + exp_in[2].size() > 0
             || yummy_owed[0] + yummy_owed[1] + yummy_owed[2] > 0
             || link_credit[0] + link_credit[1] + link_credit[2] != NCH * DEPTH)
      begin
         @(negedge core_ref_clk);
         t++;
         if (t > TIMEOUT)
         begin
            stop_on_error("timeout waiting for the inbound path to drain");
         end
      end
      repeat (2) @(negedge core_ref_clk);
   endtask

   task automatic clear_counts();
      @(negedge core_ref_clk);
      for (int c = 0; c < NCH; c++)
      begin
         yummy_cnt[c]  = 0;
         link_sent[c]  = 0;
         delivered[c]  = 0;
         cb_out_cnt[c] = 0;
      end
      link_seq.delete();
   endtask

   ////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////

   task automatic test_reset_state();
      @(negedge core_ref_clk);
      check_value("noc_in_yummy", 32'(0), 32'(noc_in_yummy));
      check_value("noc_out_valid", 32'(0), 32'(noc_out_valid));
      check_value("link_credit_back_out", 32'(0), 32'(link_credit_back_out));
      check_value("link_out_channel", 32'(noc_bridge_pkg::LINK_IDLE), 32'(link_out_channel));
   endtask

   task automatic test_outbound_order();
      clear_counts();
      send_outbound(4, 4, 4);
      wait_outbound_idle();
      for (int c = 0; c < NCH; c++)
      begin
         check_value($sformatf("link flits ch%0d", c), 32'(4), 32'(link_sent[c]));
         check_value($sformatf("noc_in_yummy count ch%0d", c), 32'(4), 32'(yummy_cnt[c]));
      end
   endtask

   // a repeat is legal only once no other channel shows up again
   task automatic test_round_robin();
      clear_counts();
      send_outbound(4, 4, 4);
      wait_outbound_idle();
      for (int i = 1; i < link_seq.size(); i++)
      begin
         if (link_seq[i] == link_seq[i-1])
         begin
            for (int j = i + 1; j < link_seq.size(); j++)
            begin
               assert (link_seq[j] == link_seq[i])
               else stop_on_error("channel granted twice in a row while another waited");
            end
         end
      end
   endtask

   task automatic test_remote_backpressure();
      clear_counts();
      auto_cb = 1'b0;
      send_outbound(8, 8, 8);
      for (int c = 0; c < NCH; c++)
      begin
         wait_link_sent(c, DEPTH);
      end
      // link must stay quiet without credits
      repeat (20) @(negedge core_ref_clk);
      for (int c = 0; c < NCH; c++)
      begin
         check_value($sformatf("link flits ch%0d", c), 32'(DEPTH), 32'(link_sent[c]));
      end
      manual_cb[0] = 1;
      wait_link_sent(0, DEPTH + 1);
      repeat (10) @(negedge core_ref_clk);
      check_value("link flits ch0", 32'(DEPTH + 1), 32'(link_sent[0]));
      check_value("link flits ch1", 32'(DEPTH), 32'(link_sent[1]));
      check_value("link flits ch2", 32'(DEPTH), 32'(link_sent[2]));
      auto_cb = 1'b1;
      wait_outbound_idle();
      for (int c = 0; c < NCH; c++)
      begin
         check_value($sformatf("link flits ch%0d", c), 32'(8), 32'(link_sent[c]));
      end
   endtask

   task automatic test_inbound_delivery();
      clear_counts();
      send_inbound(5, 3, 6);
      wait_inbound_idle();
      check_value("delivered ch0", 32'(5), 32'(delivered[0]));
      check_value("delivered ch1", 32'(3), 32'(delivered[1]));
      check_value("delivered ch2", 32'(6), 32'(delivered[2]));
      for (int c = 0; c < NCH; c++)
      begin
         check_value($sformatf("link_credit_back_out count ch%0d", c),
                     32'(delivered[c]), 32'(cb_out_cnt[c]));
      end
   endtask

   task automatic test_proc_backpressure();
      clear_counts();
      auto_yummy = 1'b0;
      send_inbound(8, 8, 8);
      for (int c = 0; c < NCH; c++)
      begin
         wait_delivered(c, DEPTH);
      end
      repeat (20) @(negedge core_ref_clk);
      for (int c = 0; c < NCH; c++)
      begin
         check_value($sformatf("delivered ch%0d", c), 32'(DEPTH), 32'(delivered[c]));
      end
      auto_yummy = 1'b1;
      wait_inbound_idle();
      for (int c = 0; c < NCH; c++)
      begin
         check_value($sformatf("delivered ch%0d", c), 32'(8), 32'(delivered[c]));
         check_value($sformatf("link_credit_back_out count ch%0d", c), 32'(8),
                     32'(cb_out_cnt[c]));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // run
   ////////////////////////////////////////////////////////////

   initial
   begin
      repeat (20000) @(posedge core_ref_clk);
      stop_on_error("global watchdog expired");
   end

   initial
   begin
      void'($urandom(32'h5c01));
      auto_cb             = 1'b1;
      auto_yummy          = 1'b1;
      rst_n               = 1'b0;
      noc_in_valid        = '0;
      noc_out_yummy       = '0;
      link_credit_back_in = '0;
      link_in_data        = '0;
      link_in_channel     = noc_bridge_pkg::LINK_IDLE;
      for (int c = 0; c < NCH; c++)
      begin
         noc_in_data[c]    = '0;
         proc_tx_credit[c] = DEPTH;
         link_credit[c]    = DEPTH;
         cb_pending[c]     = 0;
         manual_cb[c]      = 0;
         yummy_owed[c]     = 0;
      end
      repeat (5) @(posedge core_ref_clk);
      rst_n <= 1'b1;

      test_reset_state();
      test_outbound_order();
      test_round_robin();
      test_remote_backpressure();
      test_inbound_delivery();
      test_proc_backpressure();

      $display("RESULT: PASS");
      $finish;
   end

endmodule
